//--- Makefile
# Verilator build and run of the page table walker testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module tbPtw -Mdir obj_dir -f filelist.f

run: compile
	@out="$$(./obj_dir/VtbPtw)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

//--- filelist.f
sv32Pkg.sv
walkPkg.sv
missArbiter.sv
pteWalker.sv
walkResponder.sv
ptwTop.sv
tbPtw.sv

//--- missArbiter.sv
/*
  Takes one TLB miss at a time, data before instruction.
  Misses are levels held by the TLB until translationComplete.
*/
module missArbiter
  import sv32Pkg::*;
  import walkPkg::*;
(
  input  logic    HCLK,
  input  logic    arstN,
  input  logic    itlbMiss,
  input  logic    dtlbMiss,
  input  vAdrT    pc,
  input  vAdrT    memAdr,
  input  logic    memStore,
  input  logic    busyRelease,
  output logic    reqValid,
  output walkReqT req
);

  logic    missSeen;
  logic    accept;
  walkReqT nextReq;

  assign missSeen = itlbMiss || dtlbMiss;
  // Only while free, so a miss still high at release is ignored
  assign accept   = missSeen && !reqValid;

  // Data miss wins, store only matters for data
  always_comb begin
    nextReq.vAdr    = dtlbMiss ? memAdr : pc;
    nextReq.isData  = dtlbMiss;
    nextReq.isStore = dtlbMiss && memStore;
  end

  // Busy flag, doubles as the request valid
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      reqValid <= 1'b0;
    end else if (accept) begin
      reqValid <= 1'b1;
    end else if (busyRelease) begin
      reqValid <= 1'b0;
    end
  end

  // Request held stable until the release
  always_ff @(posedge HCLK) begin
    if (accept) begin
      req <= nextReq;
    end
  end

  // Responder only releases a walk that is in flight
  assert property (@(posedge HCLK) disable iff (!arstN)
    busyRelease |-> reqValid);

endmodule

//--- pteWalker.sv
/*
  Sv32 two-level walk over one word-wide memory port.
  Started only with translation on, so only the satp root PPN is read.
  No A/D update and no privilege checks here.
*/
module pteWalker
  import sv32Pkg::*;
  import walkPkg::*;
(
  input  logic        HCLK,
  input  logic        arstN,
  input  logic [31:0] satp,
  input  logic        reqValid,
  input  walkReqT     req,
  output logic        mmuTranslate,
  output pAdrT        mmuPAdr,
  input  pteT         mmuReadPte,
  input  logic        mmuReady,
  output logic        doneValid,
  output walkResultT  result
);

  walkStateT state, nextState;
  pAdrT      walkAdr, nextAdr;
  pteT       pteQ;
  pageTypeT  pageTypeQ, nextPageType;
  logic      reqValidQ;
  logic      walkStart;
  ppnT       rootPpn, ptePpn;
  logic      pteValid, pteLeaf, accessOk, megaMisaligned;
  faultKindT faultKind;

  // Table base plus scaled index
  function automatic pAdrT pteAdr(ppnT ppn, logic [VpnBits-1:0] vpn);
    pAdrT base;
    pAdrT idx;
    base = {ppn, {PageOffsetBits{1'b0}}};
    idx  = pAdrT'(vpn) * pAdrT'(PteBytes);
    return base + idx;
  endfunction

  ////////////////////////////////////////////////////////////
  // Entry checks on the returned word
  ////////////////////////////////////////////////////////////

  assign rootPpn = satp[PpnBits-1:0];
  assign ptePpn  = {mmuReadPte.ppn1, mmuReadPte.ppn0};

  // W without R is reserved
  assign pteValid       = mmuReadPte.v && !(mmuReadPte.w && !mmuReadPte.r);
  assign pteLeaf        = mmuReadPte.r || mmuReadPte.w || mmuReadPte.x;
  // Missing A, or store to a clean page
  assign accessOk       = mmuReadPte.a && !(req.isStore && !mmuReadPte.d);
  // Megapage must start on a 4 MiB boundary
  assign megaMisaligned = |mmuReadPte.ppn0;

  // Start once per request, reqValid stays high through the report
  assign walkStart = reqValid && !reqValidQ;

  ////////////////////////////////////////////////////////////
  // Level FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    nextState    = state;
    nextAdr      = walkAdr;
    nextPageType = pageTypeQ;
    case (state)
      idle: begin
        if (walkStart) begin
          nextState = level1;
          nextAdr   = pteAdr(rootPpn, req.vAdr.vpn1);
        end
      end
      level1: begin
        // Hold state and address until the memory answers
        if (mmuReady) begin
          if (!pteValid) begin
            nextState = fault;
          end else if (!pteLeaf) begin
            nextState = level0;
            nextAdr   = pteAdr(ptePpn, req.vAdr.vpn0);
          end else if (!accessOk || megaMisaligned) begin
            nextState = fault;
          end else begin
            nextState    = leaf;
            nextPageType = megaPage;
          end
        end
      end
      level0: begin
        // A pointer here has nowhere to go
        if (mmuReady) begin
          if (!pteValid || !pteLeaf || !accessOk) begin
            nextState = fault;
          end else begin
            nextState    = leaf;
            nextPageType = kiloPage;
          end
        end
      end
      default: nextState = idle;
    endcase
  end

  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      state     <= idle;
      reqValidQ <= 1'b0;
    end else begin
      state     <= nextState;
      reqValidQ <= reqValid;
    end
  end

  // Address, fetched entry and page size
  always_ff @(posedge HCLK) begin
    walkAdr   <= nextAdr;
    pageTypeQ <= nextPageType;
    if (mmuReady && mmuTranslate) begin
      pteQ <= mmuReadPte;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  assign mmuTranslate = (state == level1) || (state == level0);
  assign mmuPAdr      = walkAdr;
  assign doneValid    = (state == leaf) || (state == fault);

  assign faultKind = !req.isData ? instrFault : (req.isStore ? storeFault : loadFault);

  always_comb begin
    result.pte      = pteQ;
    result.pageType = pageTypeQ;
    result.isData   = req.isData;
    result.fault    = (state == fault) ? faultKind : noFault;
  end

  // Memory port address holds until the ready pulse
  assert property (@(posedge HCLK) disable iff (!arstN)
    mmuTranslate && !mmuReady |=> mmuTranslate && $stable(mmuPAdr));
  assert property (@(posedge HCLK) disable iff (!arstN)
    doneValid |=> !doneValid);

endmodule

//--- ptwTop.sv
/*
  Page table walker top. TLBs and the bus bridge sit outside.
  One walk in flight; satp must have translation on.
*/
module ptwTop
  import sv32Pkg::*;
  import walkPkg::*;
(
  input  logic        HCLK,
  input  logic        arstN,
  // TLB side
  input  logic        itlbMiss,
  input  logic        dtlbMiss,
  input  vAdrT        pc,
  input  vAdrT        memAdr,
  input  logic        memStore,
  input  logic [31:0] satp,
  output logic        itlbWrite,
  output logic        dtlbWrite,
  output tlbWriteT    tlbEntry,
  output logic        instrPageFault,
  output logic        loadPageFault,
  output logic        storePageFault,
  output logic        translationComplete,
  // Memory port
  output logic        mmuTranslate,
  output pAdrT        mmuPAdr,
  input  pteT         mmuReadPte,
  input  logic        mmuReady
);

  logic       reqValid;
  walkReqT    req;
  logic       doneValid;
  walkResultT result;
  logic       busyRelease;

  ////////////////////////////////////////////////////////////
  // Stage 1, miss select
  ////////////////////////////////////////////////////////////

  missArbiter u_missArbiter (
    .HCLK        (HCLK),
    .arstN       (arstN),
    .itlbMiss    (itlbMiss),
    .dtlbMiss    (dtlbMiss),
    .pc          (pc),
    .memAdr      (memAdr),
    .memStore    (memStore),
    .busyRelease (busyRelease),
    .reqValid    (reqValid),
    .req         (req)
  );

  // Stage 2, table walk
  pteWalker u_pteWalker (
    .HCLK         (HCLK),
    .arstN        (arstN),
    .satp         (satp),
    .reqValid     (reqValid),
    .req          (req),
    .mmuTranslate (mmuTranslate),
    .mmuPAdr      (mmuPAdr),
    .mmuReadPte   (mmuReadPte),
    .mmuReady     (mmuReady),
    .doneValid    (doneValid),
    .result       (result)
  );

  // Stage 3, report
  walkResponder u_walkResponder (
    .HCLK                (HCLK),
    .arstN               (arstN),
    .doneValid           (doneValid),
    .result              (result),
    .itlbWrite           (itlbWrite),
    .dtlbWrite           (dtlbWrite),
    .tlbEntry            (tlbEntry),
    .instrPageFault      (instrPageFault),
    .loadPageFault       (loadPageFault),
    .storePageFault      (storePageFault),
    .translationComplete (translationComplete),
    .busyRelease         (busyRelease)
  );

endmodule

//--- sv32Pkg.sv
/*
  Sv32 address and page table entry formats for RV32 only.
  Physical addresses are 34 bits wide. The software bits of a PTE are carried
  but never interpreted.
*/
package sv32Pkg;

  ////////////////////////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////////////////////////

  // Offset inside a 4 KiB page
  localparam int PageOffsetBits = 12;
  // One VPN slice indexes 1024 entries
  localparam int VpnBits        = 10;
  // Physical page number as held in satp and in a PTE
  localparam int PpnBits        = 22;
  localparam int PAdrBits       = PpnBits + PageOffsetBits;
  // Bytes per entry, scales a table index to a byte offset
  localparam int PteBytes       = 4;

  ////////////////////////////////////////////////////////////
  // Formats
  ////////////////////////////////////////////////////////////

  typedef logic [PpnBits-1:0]  ppnT;
  typedef logic [PAdrBits-1:0] pAdrT;

  // Virtual address split into the two table indices
  typedef struct packed {
    logic [VpnBits-1:0]        vpn1;
    logic [VpnBits-1:0]        vpn0;
    logic [PageOffsetBits-1:0] offset;
  } vAdrT;

  // Page table entry, flags in the low byte
  typedef struct packed {
    logic [11:0] ppn1;
    logic [9:0]  ppn0;
    logic [1:0]  rsw;
    logic        d;
    logic        a;
    logic        g;
    logic        u;
    logic        x;
    logic        w;
    logic        r;
    logic        v;
  } pteT;

  // Size of the page a leaf maps
  typedef enum logic [1:0] {
    kiloPage = 2'b00,
    megaPage = 2'b01
  } pageTypeT;

endpackage

//--- tbPtw.sv
/*
  Testbench for ptwTop. It models both TLBs and a page table memory that
  answers after 1 to 4 cycles. Expected results come from refWalk, which
  reads the same memory. A missing word reads as zero, an invalid entry.
*/
module tbPtw
  import sv32Pkg::*;
  import walkPkg::*;
();

  // One outstanding expectation per walk, in completion order
  typedef struct packed {
    logic      isData;
    faultKindT kind;
    tlbWriteT  entry;
  } expectT;

  logic        HCLK = 1'b0;
  logic        arstN;
  logic        itlbMiss;
  logic        dtlbMiss;
  vAdrT        pc;
  vAdrT        memAdr;
  logic        memStore;
  logic [31:0] satp;
  logic        itlbWrite;
  logic        dtlbWrite;
  tlbWriteT    tlbEntry;
  logic        instrPageFault;
  logic        loadPageFault;
  logic        storePageFault;
  logic        translationComplete;
  logic        mmuTranslate;
  pAdrT        mmuPAdr;
  pteT         mmuReadPte;
  logic        mmuReady;

  // Sparse page table memory, byte address of each word as key
  logic [31:0] pageMem [pAdrT];
  expectT      expQ [$];
  integer      seed = 32'h65e13d03;
  int          delayLeft;
  int          errCount = 0;
  int          testCount = 0;
  int          failCount = 0;

  ptwTop i_dut (.*);

  always #50 HCLK = !HCLK;

  ////////////////////////////////////////////////////////////
  // Page table memory and reference walk
  ////////////////////////////////////////////////////////////

  function automatic pteT readPte(input pAdrT adr);
    if (pageMem.exists(adr)) begin
      return pteT'(pageMem[adr]);
    end
    return '0;
  endfunction

  function automatic pteT mkPte(input ppnT ppn, input logic [7:0] flags);
    return pteT'({ppn, 2'b00, flags});
  endfunction

  function automatic vAdrT vaOf(input logic [9:0] vpn1, input logic [9:0] vpn0);
    return vAdrT'({vpn1, vpn0, 12'h3a8});
  endfunction

  task automatic putPte(input ppnT tbl, input logic [9:0] idx, input pteT e);
    pageMem[(pAdrT'(tbl) << 12) + pAdrT'(idx) * 4] = e;
  endtask

  // Sv32 translation, walked top down from the satp root
  function automatic faultKindT refWalk(input logic [31:0] satpV, input walkReqT walk,
                                        output tlbWriteT entry);
    pAdrT       tblAdr;
    pteT        e;
    faultKindT  kind;
    logic [9:0] idx;
    int         level;
    kind   = walk.isData ? (walk.isStore ? storeFault : loadFault) : instrFault;
    entry  = '0;
    tblAdr = pAdrT'(satpV[21:0]) << 12;
    for (level = 1; level >= 0; level--) begin
      idx = (level == 1) ? walk.vAdr.vpn1 : walk.vAdr.vpn0;
      e   = readPte(tblAdr + pAdrT'(idx) * 4);
      // Not valid, or writable without readable
      if (!e.v || (e.w && !e.r)) begin
        return kind;
      end
      if (e.r || e.x) begin
        // Megapage must sit on a 4 MiB boundary
        if (level == 1 && e.ppn0 != '0) begin
          return kind;
        end
        if (!e.a || (walk.isStore && !e.d)) begin
          return kind;
        end
        entry.pte      = e;
        entry.pageType = (level == 1) ? megaPage : kiloPage;
        return noFault;
      end
      tblAdr = pAdrT'({e.ppn1, e.ppn0}) << 12;
    end
    // Ran out of levels on a pointer
    return kind;
  endfunction

  // Memory port, one ready pulse per request after a random delay
  initial begin : memoryModel
    mmuReady   = 1'b0;
    mmuReadPte = '0;
    delayLeft  = 0;
    forever begin
      @(posedge HCLK);
      #1;
      mmuReady = 1'b0;
      if (arstN && mmuTranslate) begin
        if (delayLeft == 0) begin
          delayLeft = 1 + int'($unsigned($random(seed)) % 4);
        end
        delayLeft--;
        if (delayLeft == 0) begin
          mmuReadPte = readPte(mmuPAdr);
          mmuReady   = 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Output checks
  ////////////////////////////////////////////////////////////

  function automatic faultKindT observedFault();
    if (instrPageFault) return instrFault;
    if (loadPageFault) return loadFault;
    if (storePageFault) return storeFault;
    return noFault;
  endfunction

  task automatic checkRefill(input tlbWriteT expEntry, input logic expData);
    if ({itlbWrite, dtlbWrite} != {!expData, expData}) begin
      $display("mismatch itlbWrite/dtlbWrite: expected %h, got %h",
               {!expData, expData}, {itlbWrite, dtlbWrite});
      errCount++;
    end
    if (tlbEntry != expEntry) begin
      $display("mismatch tlbEntry: expected %h, got %h", expEntry, tlbEntry);
      errCount++;
    end
    if (observedFault() != noFault) begin
      $display("mismatch pageFault: expected %h, got %h", noFault, observedFault());
      errCount++;
    end
  endtask

  task automatic checkFault(input faultKindT expKind);
    if (observedFault() != expKind) begin
      $display("mismatch pageFault: expected %h, got %h", expKind, observedFault());
      errCount++;
    end
    if (itlbWrite || dtlbWrite) begin
      $display("mismatch itlbWrite/dtlbWrite: expected %h, got %h",
               2'b00, {itlbWrite, dtlbWrite});
      errCount++;
    end
  endtask

  // Mid-cycle, registered outputs are settled
  always @(negedge HCLK) begin : compareOutputs
    expectT want;
    if (arstN && translationComplete) begin
      if (expQ.size() == 0) begin
        $display("translationComplete arrived with no walk outstanding");
        errCount++;
      end else begin
        want = expQ.pop_front();
        if (want.kind == noFault) begin
          checkRefill(want.entry, want.isData);
        end else begin
          checkFault(want.kind);
        end
      end
    end else if (arstN && (itlbWrite || dtlbWrite || observedFault() != noFault)) begin
      $display("a report pulse fired without translationComplete");
      errCount++;
    end
  end

  ////////////////////////////////////////////////////////////
  // Test steps
  ////////////////////////////////////////////////////////////

  task automatic reportTest(input string name, input int errBefore);
    testCount++;
    if (errCount == errBefore) begin
      $display("%0s: ok", name);
    end else begin
      $display("%0s: %0d error(s)", name, errCount - errBefore);
      failCount++;
    end
  endtask

  task automatic waitComplete(input string name, output logic seen);
    int cycles;
    seen = 1'b0;
    for (cycles = 0; cycles < 200 && !seen; cycles++) begin
      @(posedge HCLK);
      #1;
      seen = translationComplete;
    end
    if (!seen) begin
      $display("%0s got no translationComplete within 200 cycles", name);
      errCount++;
      expQ.delete();
    end
  endtask

  // Queue the reference result and cross check it against the intent
  task automatic expectWalk(input logic isData, input logic isStore, input vAdrT va,
                            input faultKindT planKind);
    walkReqT  walk;
    tlbWriteT entry;
    expectT   want;
    walk.vAdr    = va;
    walk.isData  = isData;
    walk.isStore = isStore;
    want.kind    = refWalk(satp, walk, entry);
    want.isData  = isData;
    want.entry   = entry;
    if (want.kind != planKind) begin
      $display("reference walk gives %0s where %0s was intended",
               want.kind.name(), planKind.name());
      errCount++;
    end
    expQ.push_back(want);
  endtask

  task automatic runWalk(input string name, input logic isData, input logic isStore,
                         input vAdrT va, input faultKindT planKind);
    int   errBefore;
    logic seen;
    errBefore = errCount;
    expectWalk(isData, isStore, va, planKind);
    if (isData) begin
      memAdr   = va;
      memStore = isStore;
      dtlbMiss = 1'b1;
    end else begin
      pc       = va;
      itlbMiss = 1'b1;
    end
    waitComplete(name, seen);
    // TLB drops its miss in the report cycle
    itlbMiss = 1'b0;
    dtlbMiss = 1'b0;
    memStore = 1'b0;
    @(posedge HCLK);
    #1;
    reportTest(name, errBefore);
  endtask

  task automatic idleCheck();
    int n;
    int errBefore;
    errBefore = errCount;
    for (n = 0; n < 8; n++) begin
      @(posedge HCLK);
      #1;
      if (mmuTranslate || itlbWrite || dtlbWrite || observedFault() != noFault ||
          translationComplete) begin
        $display("memory request or report pulse seen with no miss pending");
        errCount++;
      end
    end
    reportTest("idle after reset", errBefore);
  endtask

  task automatic directedWalks();
    pageMem.delete();
    satp = {1'b1, 9'd0, 22'h00040};
    // Flags are DAGUXWRV
    putPte(22'h00040, 10'd1, mkPte(22'h00041, 8'h01));
    putPte(22'h00040, 10'd3, mkPte({12'h0ab, 10'h000}, 8'hcf));
    putPte(22'h00040, 10'd4, mkPte({12'h0ab, 10'h001}, 8'hcf));
    // RWX set but V clear
    putPte(22'h00040, 10'd5, mkPte(22'h01234, 8'h0e));
    putPte(22'h00040, 10'd7, mkPte({12'h0cd, 10'h000}, 8'h8b));
    // Level-0 table, execute only leaf
    putPte(22'h00041, 10'd2, mkPte(22'h12345, 8'h49));
    // Read write leaf, clean
    putPte(22'h00041, 10'd8, mkPte(22'h23456, 8'h47));
    putPte(22'h00041, 10'd9, mkPte(22'h00042, 8'h01));
    putPte(22'h00041, 10'd10, mkPte(22'h34567, 8'hc5));
    runWalk("instr kilopage", 1'b0, 1'b0, vaOf(10'd1, 10'd2), noFault);
    runWalk("load megapage", 1'b1, 1'b0, vaOf(10'd3, 10'd77), noFault);
    runWalk("instr misaligned megapage", 1'b0, 1'b0, vaOf(10'd4, 10'd0), instrFault);
    runWalk("load misaligned megapage", 1'b1, 1'b0, vaOf(10'd4, 10'd5), loadFault);
    runWalk("load invalid entry", 1'b1, 1'b0, vaOf(10'd5, 10'd0), loadFault);
    runWalk("load W without R", 1'b1, 1'b0, vaOf(10'd1, 10'd10), loadFault);
    runWalk("instr no accessed bit", 1'b0, 1'b0, vaOf(10'd7, 10'd0), instrFault);
    runWalk("store clean page", 1'b1, 1'b1, vaOf(10'd1, 10'd8), storeFault);
    runWalk("load clean page", 1'b1, 1'b0, vaOf(10'd1, 10'd8), noFault);
    runWalk("load pointer at level 0", 1'b1, 1'b0, vaOf(10'd1, 10'd9), loadFault);
  endtask

  // Both misses at once, uses the directed tables
  task automatic bothMisses();
    int   errBefore;
    logic seen;
    errBefore = errCount;
    expectWalk(1'b1, 1'b0, vaOf(10'd3, 10'd9), noFault);
    expectWalk(1'b0, 1'b0, vaOf(10'd1, 10'd2), noFault);
    memAdr   = vaOf(10'd3, 10'd9);
    pc       = vaOf(10'd1, 10'd2);
    memStore = 1'b0;
    itlbMiss = 1'b1;
    dtlbMiss = 1'b1;
    waitComplete("data walk of two", seen);
    dtlbMiss = 1'b0;
    waitComplete("instr walk of two", seen);
    itlbMiss = 1'b0;
    @(posedge HCLK);
    #1;
    reportTest("both misses, data first", errBefore);
  endtask

  // Mostly valid and accessed, so refills stay common
  function automatic pteT randomPte(input logic pointer);
    pteT e;
    e = pteT'($random(seed));
    if (($random(seed) & 7) != 0) e.v = 1'b1;
    if (($random(seed) & 3) != 0) e.a = 1'b1;
    if (pointer) begin
      {e.x, e.w, e.r} = 3'b000;
    end else if (!(e.r || e.w || e.x)) begin
      e.r = 1'b1;
    end
    return e;
  endfunction

  task automatic randomWalks();
    int       n;
    ppnT      root;
    ppnT      mid;
    vAdrT     va;
    pteT      l1;
    logic     isData;
    logic     isStore;
    walkReqT  walk;
    tlbWriteT entry;
    for (n = 0; n < 40; n++) begin
      pageMem.delete();
      root    = ppnT'($random(seed));
      mid     = ppnT'($random(seed));
      va      = vAdrT'($random(seed));
      isData  = ($random(seed) & 1) != 0;
      isStore = isData && (($random(seed) & 1) != 0);
      satp    = {1'b1, 9'd0, root};
      l1      = randomPte(($random(seed) & 1) != 0);
      if (!(l1.r || l1.w || l1.x)) begin
        {l1.ppn1, l1.ppn0} = mid;
      end else if (($random(seed) & 1) != 0) begin
        l1.ppn0 = '0;
      end
      putPte(root, va.vpn1, l1);
      // Rarely a pointer at level 0
      putPte(mid, va.vpn0, randomPte(($random(seed) & 7) == 0));
      walk.vAdr    = va;
      walk.isData  = isData;
      walk.isStore = isStore;
      runWalk($sformatf("random walk %0d", n), isData, isStore, va,
              refWalk(satp, walk, entry));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    arstN    = 1'b0;
    itlbMiss = 1'b0;
    dtlbMiss = 1'b0;
    pc       = '0;
    memAdr   = '0;
    memStore = 1'b0;
    satp     = {1'b1, 9'd0, 22'h00040};
    repeat (5) @(posedge HCLK);
    #1;
    arstN = 1'b1;
    idleCheck();
    directedWalks();
    bothMisses();
    randomWalks();
    if (expQ.size() != 0) begin
      $display("%0d expected walks were never reported", expQ.size());
      errCount++;
    end
    $display("%0d tests run, %0d with errors, %0d errors in total",
             testCount, failCount, errCount);
    if (errCount == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- walkPkg.sv
/*
  Walker states, fault kinds and the records passed between the three
  stages of the page table walker. Built on the Sv32 formats.
*/
package walkPkg;
  import sv32Pkg::*;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // leaf and fault last one cycle each
  typedef enum logic [2:0] {
    idle,
    level1,
    level0,
    leaf,
    fault
  } walkStateT;

  typedef enum logic [1:0] {
    noFault,
    instrFault,
    loadFault,
    storeFault
  } faultKindT;

  ////////////////////////////////////////////////////////////
  // Stage records
  ////////////////////////////////////////////////////////////

  // Latched miss, held for the whole walk
  typedef struct packed {
    vAdrT vAdr;
    logic isData;
    logic isStore;
  } walkReqT;

  // Walk outcome, fault is noFault for a refill
  typedef struct packed {
    pteT       pte;
    pageTypeT  pageType;
    logic      isData;
    faultKindT fault;
  } walkResultT;

  // Refill seen by a TLB
  typedef struct packed {
    pteT      pte;
    pageTypeT pageType;
  } tlbWriteT;

endpackage

//--- walkResponder.sv
/*
  Turns a walk outcome into one registered report pulse, one cycle after
  doneValid. The refill goes to the TLB that missed.
*/
module walkResponder
  import sv32Pkg::*;
  import walkPkg::*;
(
  input  logic       HCLK,
  input  logic       arstN,
  input  logic       doneValid,
  input  walkResultT result,
  output logic       itlbWrite,
  output logic       dtlbWrite,
  output tlbWriteT   tlbEntry,
  output logic       instrPageFault,
  output logic       loadPageFault,
  output logic       storePageFault,
  output logic       translationComplete,
  output logic       busyRelease
);

  logic refill;

  assign refill = doneValid && (result.fault == noFault);

  // One-cycle report pulses
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      itlbWrite           <= 1'b0;
      dtlbWrite           <= 1'b0;
      instrPageFault      <= 1'b0;
      loadPageFault       <= 1'b0;
      storePageFault      <= 1'b0;
      translationComplete <= 1'b0;
    end else begin
      itlbWrite           <= refill && !result.isData;
      dtlbWrite           <= refill && result.isData;
      instrPageFault      <= doneValid && (result.fault == instrFault);
      loadPageFault       <= doneValid && (result.fault == loadFault);
      storePageFault      <= doneValid && (result.fault == storeFault);
      translationComplete <= doneValid;
    end
  end

  // Entry only meaningful with a write pulse
  always_ff @(posedge HCLK) begin
    if (refill) begin
      tlbEntry.pte      <= result.pte;
      tlbEntry.pageType <= result.pageType;
    end
  end

  // Arbiter frees up in the cycle the report fires
  assign busyRelease = translationComplete;

  // At most one report pulse at a time
  assert property (@(posedge HCLK) disable iff (!arstN)
    $onehot0({itlbWrite, dtlbWrite, instrPageFault, loadPageFault, storePageFault}));

endmodule
